/* source/amo_mem_pkg.sv */
/*
  Word store geometry for the atomic memory unit, with the data
  and address types shared by all stages
*/
`default_nettype none

package amo_mem_pkg;

  // Store of 64-bit words behind a small byte address
  localparam int MEM_WORDS  = 32;
  localparam int ADDR_W     = 8;
  localparam int WORD_W     = 64;
  localparam int HALF_W     = 32;

  // Byte offset bits inside one word
  localparam int WORD_OFFS  = 3;
  localparam int WORD_IDX_W = ADDR_W - WORD_OFFS;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [HALF_W-1:0]     half_t;
  typedef logic [ADDR_W-1:0]     byte_addr_t;
  typedef logic [WORD_IDX_W-1:0] word_idx_t;

endpackage

`default_nettype wire

/* source/amo_ops_pkg.sv */
/*
  Atomic operation codes, size codes, the request and response
  structs, and the structs passed between the pipeline stages
*/
`default_nettype none

package amo_ops_pkg;

  // RISC-V atomics, encoded as in the cache interface
  typedef enum logic [3:0] {
    AMO_NONE = 4'b0000,
    AMO_LR   = 4'b0001,
    AMO_SC   = 4'b0010,
    AMO_SWAP = 4'b0011,
    AMO_ADD  = 4'b0100,
    AMO_AND  = 4'b0101,
    AMO_OR   = 4'b0110,
    AMO_XOR  = 4'b0111,
    AMO_MAX  = 4'b1000,
    AMO_MAXU = 4'b1001,
    AMO_MIN  = 4'b1010,
    AMO_MINU = 4'b1011
  } amo_op_e;

  // Access size as log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_W = 2'b10,
    SIZE_D = 2'b11
  } amo_size_e;

  typedef struct packed {
    logic                   req;
    amo_op_e                amo_op;
    amo_size_e              size;
    amo_mem_pkg::byte_addr_t operand_a;
    amo_mem_pkg::word_t     operand_b;
  } amo_req_t;

  typedef struct packed {
    logic               ack;
    amo_mem_pkg::word_t result;
  } amo_resp_t;

  // Accepted operation, decode to execute and result
  typedef struct packed {
    amo_op_e                 op;
    logic                    is_word;
    logic                    hi_half;
    amo_mem_pkg::word_idx_t  word_idx;
    amo_mem_pkg::byte_addr_t byte_addr;
    amo_mem_pkg::word_t      operand_b;
  } decoded_t;

  // Execute outputs, valid for one cycle
  typedef struct packed {
    logic                    valid;
    amo_op_e                 op;
    logic                    is_word;
    logic                    hi_half;
    amo_mem_pkg::word_idx_t  word_idx;
    amo_mem_pkg::byte_addr_t byte_addr;
    amo_mem_pkg::word_t      new_value;
    amo_mem_pkg::word_t      rd_value;
  } exec_t;

endpackage

`default_nettype wire

/* source/amo_decode.sv */
/*
  Request stage of the atomic unit. Accepts one request while idle,
  holds it and presents the decoded operation for one cycle
*/
`timescale 1ns/1ns
`default_nettype none

module amo_decode (
  input  logic                  rst_ni,
  input  logic                  reset_i,
  input  amo_ops_pkg::amo_req_t req_i,
  input  logic                  ack_i,
  output logic                  dec_valid_o,
  output amo_ops_pkg::decoded_t dec_o
);
  import amo_mem_pkg::*;
  import amo_ops_pkg::*;

  logic     busy_q;
  logic     dec_valid_q;
  logic     accept;
  decoded_t dec_d;
  decoded_t dec_q;

  // Codes outside the supported set become no-ops
  function automatic amo_op_e map_op(input amo_op_e op);
    case (op)
      AMO_LR, AMO_SC, AMO_SWAP, AMO_ADD, AMO_AND, AMO_OR,
      AMO_XOR, AMO_MAX, AMO_MAXU, AMO_MIN, AMO_MINU: return op;
      default: return AMO_NONE;
    endcase
  endfunction

  // No new request during busy or in the ack cycle
  assign accept = req_i.req && !busy_q && !ack_i;

  always_comb begin
    dec_d.op        = map_op(req_i.amo_op);
    dec_d.is_word   = (req_i.size == SIZE_W);
    dec_d.hi_half   = req_i.operand_a[2];
    dec_d.word_idx  = req_i.operand_a[ADDR_W-1:WORD_OFFS];
    dec_d.byte_addr = req_i.operand_a;
    dec_d.operand_b = req_i.operand_b;
  end

  always_ff @(posedge rst_ni) begin
    if (reset_i) begin
      busy_q      <= 1'b0;
      dec_valid_q <= 1'b0;
    end else begin
      dec_valid_q <= accept;
      if (accept) begin
        busy_q <= 1'b1;
        dec_q  <= dec_d;
      end else if (ack_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign dec_valid_o = dec_valid_q;
  assign dec_o       = dec_q;

  ////////////////////////////////////////////////////////////////////////////
  // Requester protocol checks
  ////////////////////////////////////////////////////////////////////////////

  a_addr_aligned: assert property (@(posedge rst_ni) disable iff (reset_i)
    accept |-> ((req_i.size == SIZE_W) ? (req_i.operand_a[1:0] == 2'b00)
                                        : (req_i.operand_a[2:0] == 3'b000)));

  // Request fields are held until the acknowledge
  a_req_stable: assert property (@(posedge rst_ni) disable iff (reset_i)
    (req_i.req && !ack_i) |=> $stable(req_i));

endmodule

`default_nettype wire

/* source/amo_execute.sv */
/*
  Execute stage. Builds the operands from the old word, computes the
  new memory value and the rd value, and registers them as exec_t
*/
`timescale 1ns/1ns
`default_nettype none

module amo_execute (
  input  logic                  rst_ni,
  input  logic                  reset_i,
  input  logic                  dec_valid_i,
  input  amo_ops_pkg::decoded_t dec_i,
  input  amo_mem_pkg::word_t    old_word_i,
  output amo_ops_pkg::exec_t    exec_o
);
  import amo_mem_pkg::*;
  import amo_ops_pkg::*;

  half_t old_half;
  word_t op_a;
  word_t op_b;
  word_t op_a_u;
  word_t op_b_u;
  word_t new_val;
  exec_t exec_q;

  ////////////////////////////////////////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    old_half = dec_i.hi_half ? old_word_i[WORD_W-1:HALF_W] : old_word_i[HALF_W-1:0];
    if (dec_i.is_word) begin
      // 32-bit ops see the addressed half and the low half of operand_b
      op_a   = {{(WORD_W-HALF_W){old_half[HALF_W-1]}}, old_half};
      op_b   = {{(WORD_W-HALF_W){dec_i.operand_b[HALF_W-1]}}, dec_i.operand_b[HALF_W-1:0]};
      op_a_u = {{(WORD_W-HALF_W){1'b0}}, old_half};
      op_b_u = {{(WORD_W-HALF_W){1'b0}}, dec_i.operand_b[HALF_W-1:0]};
    end else begin
      op_a   = old_word_i;
      op_b   = dec_i.operand_b;
      op_a_u = old_word_i;
      op_b_u = dec_i.operand_b;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (dec_i.op)
      AMO_SC:   new_val = op_b;
      AMO_SWAP: new_val = op_b;
      AMO_ADD:  new_val = op_a + op_b;
      AMO_AND:  new_val = op_a & op_b;
      AMO_OR:   new_val = op_a | op_b;
      AMO_XOR:  new_val = op_a ^ op_b;
      AMO_MAX:  new_val = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
      AMO_MIN:  new_val = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
      AMO_MAXU: new_val = (op_a_u > op_b_u) ? op_a : op_b;
      AMO_MINU: new_val = (op_a_u < op_b_u) ? op_a : op_b;
      // LR and no-op leave memory as it was
      default:  new_val = op_a;
    endcase
  end

  // Registered operation result for the result stage
  always_ff @(posedge rst_ni) begin
    if (reset_i) begin
      exec_q.valid <= 1'b0;
    end else begin
      exec_q <= '{valid:     dec_valid_i,
                  op:        dec_i.op,
                  is_word:   dec_i.is_word,
                  hi_half:   dec_i.hi_half,
                  word_idx:  dec_i.word_idx,
                  byte_addr: dec_i.byte_addr,
                  new_value: new_val,
                  rd_value:  op_a};
    end
  end

  assign exec_o = exec_q;

  // One operation in flight means valid never repeats
  a_valid_pulse: assert property (@(posedge rst_ni) disable iff (reset_i)
    exec_o.valid |=> !exec_o.valid);

endmodule

`default_nettype wire

/* source/amo_result.sv */
/*
  Result stage. Holds the word store and the LR reservation, decides
  SC, writes back the new value and returns the acknowledge
*/
`timescale 1ns/1ns
`default_nettype none

module amo_result (
  input  logic                   rst_ni,
  input  logic                   reset_i,
  input  amo_mem_pkg::word_idx_t rd_idx_i,
  output amo_mem_pkg::word_t     old_word_o,
  input  amo_ops_pkg::exec_t     exec_i,
  output amo_ops_pkg::amo_resp_t resp_o
);
  import amo_mem_pkg::*;
  import amo_ops_pkg::*;

  word_t      store_q [MEM_WORDS];
  logic       resv_valid_q;
  byte_addr_t resv_addr_q;
  word_t      cur_word;
  word_t      wr_word;
  word_t      rd_final;
  logic       sc_ok;
  logic       do_write;
  logic       ack_q;
  word_t      result_q;

  // Old word for the execute stage
  assign old_word_o = store_q[rd_idx_i];
  assign cur_word   = store_q[exec_i.word_idx];

  // SC needs a live reservation on the very same byte address
  assign sc_ok = resv_valid_q && (resv_addr_q == exec_i.byte_addr);

  ////////////////////////////////////////////////////////////////////////////
  // Write-back data and rd value
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    wr_word = exec_i.new_value;
    if (exec_i.is_word) begin
      if (exec_i.hi_half) begin
        wr_word = {exec_i.new_value[HALF_W-1:0], cur_word[HALF_W-1:0]};
      end else begin
        wr_word = {cur_word[WORD_W-1:HALF_W], exec_i.new_value[HALF_W-1:0]};
      end
    end

    do_write = exec_i.valid && ((exec_i.op != AMO_SC) || sc_ok);

    rd_final = exec_i.rd_value;
    if (exec_i.op == AMO_SC) begin
      rd_final = sc_ok ? '0 : word_t'(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Store and reservation
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge rst_ni) begin
    if (reset_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        store_q[i] <= '0;
      end
      resv_valid_q <= 1'b0;
    end else begin
      if (do_write) begin
        store_q[exec_i.word_idx] <= wr_word;
      end
      if (exec_i.valid) begin
        if (exec_i.op == AMO_LR) begin
          resv_valid_q <= 1'b1;
          resv_addr_q  <= exec_i.byte_addr;
        end else if (exec_i.op == AMO_SC) begin
          // Any SC drops the reservation, pass or fail
          resv_valid_q <= 1'b0;
        end
      end
    end
  end

  // Response
  always_ff @(posedge rst_ni) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= exec_i.valid;
      if (exec_i.valid) begin
        result_q <= rd_final;
      end
    end
  end

  assign resp_o = '{ack: ack_q, result: result_q};

  a_ack_pulse: assert property (@(posedge rst_ni) disable iff (reset_i)
    resp_o.ack |=> !resp_o.ack);

endmodule

`default_nettype wire

/* source/amo_top.sv */
/*
  Atomic memory unit top level. Decode, execute and result stages
  with the acknowledge routed back to decode
*/
`timescale 1ns/1ns
`default_nettype none

module amo_top (
  input  logic                   rst_ni,
  input  logic                   reset_i,
  input  amo_ops_pkg::amo_req_t  amo_req_i,
  output amo_ops_pkg::amo_resp_t amo_resp_o
);
  import amo_mem_pkg::*;
  import amo_ops_pkg::*;

  logic     dec_valid;
  decoded_t dec;
  word_t    old_word;
  exec_t    exec;

  amo_decode i_decode (
    .rst_ni      ( rst_ni         ),
    .reset_i     ( reset_i        ),
    .req_i       ( amo_req_i      ),
    .ack_i       ( amo_resp_o.ack ),
    .dec_valid_o ( dec_valid      ),
    .dec_o       ( dec            )
  );

  amo_execute i_execute (
    .rst_ni      ( rst_ni    ),
    .reset_i     ( reset_i   ),
    .dec_valid_i ( dec_valid ),
    .dec_i       ( dec       ),
    .old_word_i  ( old_word  ),
    .exec_o      ( exec      )
  );

  // Store read port follows the held decoded word index
  amo_result i_result (
    .rst_ni     ( rst_ni       ),
    .reset_i    ( reset_i      ),
    .rd_idx_i   ( dec.word_idx ),
    .old_word_o ( old_word     ),
    .exec_i     ( exec         ),
    .resp_o     ( amo_resp_o   )
  );

endmodule

`default_nettype wire

/* test/amo_checker.sv */
/*
  Checker for the atomic memory unit testbench. Keeps a shadow store
  and reservation, predicts every response and checks ack timing
*/
`timescale 1ns/1ns
`default_nettype none

module amo_checker (
  input  logic                   rst_ni,
  input  logic                   reset_i,
  input  amo_ops_pkg::amo_req_t  req_i,
  input  amo_ops_pkg::amo_resp_t resp_i,
  output int                     err_cnt_o,
  output int                     chk_cnt_o
);
  import amo_mem_pkg::*;
  import amo_ops_pkg::*;

  // Edges from the accepting edge to the edge that samples ack high
  localparam int ACK_DELAY = 3;

  string      test_name = "none";
  word_t      shadow [MEM_WORDS];
  logic       resv_valid = 1'b0;
  byte_addr_t resv_addr;
  logic       pending = 1'b0;
  int         cyc = 0;
  int         acc_cyc = 0;
  int         errs = 0;
  int         checks = 0;
  word_t      exp_rd;
  amo_op_e    exp_op;
  byte_addr_t exp_addr;

  assign err_cnt_o = errs;
  assign chk_cnt_o = checks;

  // Expected rd value and memory word after one atomic
  function automatic void ref_amo(
    input  amo_op_e    op,
    input  logic       is_w,
    input  byte_addr_t addr,
    input  word_t      b,
    input  word_t      old_word,
    input  logic       resv_ok,
    output word_t      rd,
    output word_t      new_word
  );
    half_t old_h;
    word_t a_v;
    word_t b_v;
    word_t res;
    old_h = addr[2] ? old_word[63:32] : old_word[31:0];
    // 32-bit values moved to the top half, so 64-bit math gives the 32-bit answer
    a_v = is_w ? {old_h, 32'h0} : old_word;
    b_v = is_w ? {b[31:0], 32'h0} : b;
    case (op)
      AMO_SC, AMO_SWAP: res = b_v;
      AMO_ADD:  res = a_v + b_v;
      AMO_AND:  res = a_v & b_v;
      AMO_OR:   res = a_v | b_v;
      AMO_XOR:  res = a_v ^ b_v;
      AMO_MAX:  res = ($signed(a_v) > $signed(b_v)) ? a_v : b_v;
      AMO_MIN:  res = ($signed(a_v) < $signed(b_v)) ? a_v : b_v;
      AMO_MAXU: res = (a_v > b_v) ? a_v : b_v;
      AMO_MINU: res = (a_v < b_v) ? a_v : b_v;
      default:  res = a_v;
    endcase
    rd = is_w ? {{32{old_h[31]}}, old_h} : old_word;
    new_word = old_word;
    if (!is_w) begin
      new_word = res;
    end else if (addr[2]) begin
      new_word[63:32] = res[63:32];
    end else begin
      new_word[31:0] = res[63:32];
    end
    if (op == AMO_SC) begin
      rd = resv_ok ? 64'd0 : 64'd1;
      if (!resv_ok) begin
        new_word = old_word;
      end
    end
  endfunction

  always @(posedge rst_ni) begin
    word_t new_word;
    logic  resv_ok;
    cyc = cyc + 1;
    if (reset_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        shadow[i] = '0;
      end
      resv_valid = 1'b0;
      pending    = 1'b0;
      if (resp_i.ack) begin
        errs++;
        $display("test %s: ack went high during reset", test_name);
      end
    end else begin
      if (resp_i.ack) begin
        if (!pending) begin
          errs++;
          $display("test %s: ack seen with no request pending", test_name);
        end else begin
          if (cyc - acc_cyc != ACK_DELAY) begin
            errs++;
            $display("test %s: ack came %0d edges after accept, not %0d",
                     test_name, cyc - acc_cyc, ACK_DELAY);
          end
          checks++;
          if (resp_i.result !== exp_rd) begin
            errs++;
            $display("error: test %s, %s at %h, expected %h, actual %h",
                     test_name, exp_op.name(), exp_addr, exp_rd, resp_i.result);
          end
          pending = 1'b0;
        end
      end else if (pending && (cyc - acc_cyc >= ACK_DELAY)) begin
        errs++;
        $display("test %s: no ack by the expected edge after accept", test_name);
        pending = 1'b0;
      end

      // Accept only when idle and outside the ack cycle
      if (req_i.req && !pending && !resp_i.ack) begin
        exp_op   = req_i.amo_op;
        exp_addr = req_i.operand_a;
        resv_ok  = resv_valid && (resv_addr == req_i.operand_a);
        ref_amo(req_i.amo_op, req_i.size == SIZE_W, req_i.operand_a, req_i.operand_b,
                shadow[req_i.operand_a[7:3]], resv_ok, exp_rd, new_word);
        shadow[req_i.operand_a[7:3]] = new_word;
        if (req_i.amo_op == AMO_LR) begin
          resv_valid = 1'b1;
          resv_addr  = req_i.operand_a;
        end else if (req_i.amo_op == AMO_SC) begin
          resv_valid = 1'b0;
        end
        pending = 1'b1;
        acc_cyc = cyc;
      end
    end
  end

endmodule

`default_nettype wire

/* test/amo_tb.sv */
/*
  Testbench top for the atomic memory unit. Clock, reset, LFSR
  stimulus, the test sequence, watchdog, UUT and checker
*/
`timescale 1ns/1ns
`default_nettype none

module amo_tb;
  import amo_mem_pkg::*;
  import amo_ops_pkg::*;

  localparam int CLK_PERIOD    = 10;
  localparam int RESET_CYCLES  = 3;
  // 8 + 32 + 48 + 36 + 18 + 30 operations over the six tests
  localparam int TOTAL_OPS     = 172;
  localparam int OP_CYCLES     = 8;
  localparam int MARGIN_CYCLES = 50;

  logic        rst_ni;
  logic        reset_i;
  amo_req_t    amo_req;
  amo_resp_t   amo_resp;
  logic [15:0] lfsr_q;
  int          err_cnt;
  int          chk_cnt;
  int          op_cnt;
  int          test_cnt;
  int          test_errs;
  int          test_ops;

  amo_top UUT (
    .rst_ni     ( rst_ni   ),
    .reset_i    ( reset_i  ),
    .amo_req_i  ( amo_req  ),
    .amo_resp_o ( amo_resp )
  );

  amo_checker i_checker (
    .rst_ni    ( rst_ni   ),
    .reset_i   ( reset_i  ),
    .req_i     ( amo_req  ),
    .resp_i    ( amo_resp ),
    .err_cnt_o ( err_cnt  ),
    .chk_cnt_o ( chk_cnt  )
  );

  initial begin
    rst_ni = 1'b0;
    forever #(CLK_PERIOD / 2) rst_ni = ~rst_ni;
  end

  // Watchdog sized for the worst case of every operation
  initial begin
    #(CLK_PERIOD * (TOTAL_OPS * OP_CYCLES + MARGIN_CYCLES));
    $display("timeout: the tests did not finish in the expected time");
    $display("sim failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and request driving
  ////////////////////////////////////////////////////////////////////////////

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output word_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
  endtask

  task automatic draw_addr(input amo_size_e size, output byte_addr_t addr);
    word_t r;
    draw_bits(6, r);
    addr = {r[5:1], ((size == SIZE_W) ? r[0] : 1'b0), 2'b00};
  endtask

  // Pick from a run of consecutive op codes
  function automatic amo_op_e op_from(input int base, input int span, input word_t r);
    return amo_op_e'(4'(base + int'(r[7:0]) % span));
  endfunction

  // Called on a falling edge, returns on a falling edge
  task automatic run_op(input amo_op_e op, input amo_size_e size, input byte_addr_t addr,
                        input word_t b);
    word_t gap;
    amo_req.req       = 1'b1;
    amo_req.amo_op    = op;
    amo_req.size      = size;
    amo_req.operand_a = addr;
    amo_req.operand_b = b;
    @(negedge rst_ni);
    while (!amo_resp.ack) begin
      @(negedge rst_ni);
    end
    @(negedge rst_ni);
    amo_req.req = 1'b0;
    op_cnt++;
    draw_bits(2, gap);
    repeat (gap[1:0]) @(negedge rst_ni);
  endtask

  task automatic begin_test(input string name);
    i_checker.test_name = name;
    test_errs = err_cnt;
    test_ops  = op_cnt;
  endtask

  task automatic end_test(input string name);
    $display("test %-12s %3d ops, %0d errors", name, op_cnt - test_ops, err_cnt - test_errs);
    test_cnt++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    word_t      r;
    word_t      b;
    word_t      seed;
    byte_addr_t a;
    byte_addr_t a2;
    amo_size_e  sz;
    lfsr_q   = 16'd14698;
    amo_req  = '0;
    reset_i  = 1'b1;
    op_cnt   = 0;
    test_cnt = 0;
    repeat (RESET_CYCLES) @(posedge rst_ni);
    @(negedge rst_ni);
    reset_i = 1'b0;

    begin_test("reset_state");
    repeat (4) @(negedge rst_ni);
    for (int i = 0; i < 8; i++) begin
      draw_addr(SIZE_D, a);
      run_op(AMO_LR, SIZE_D, a, '0);
    end
    end_test("reset_state");

    // Three stacked ops on one word, then read it back
    begin_test("arith_64");
    for (int i = 0; i < 8; i++) begin
      draw_addr(SIZE_D, a);
      for (int j = 0; j < 3; j++) begin
        draw_bits(8, r);
        draw_bits(64, b);
        run_op(op_from(3, 5, r), SIZE_D, a, b);
      end
      run_op(AMO_LR, SIZE_D, a, '0);
    end
    end_test("arith_64");

    begin_test("min_max");
    for (int i = 0; i < 16; i++) begin
      draw_bits(1, r);
      sz = r[0] ? SIZE_W : SIZE_D;
      draw_addr(sz, a);
      draw_bits(64, seed);
      draw_bits(64, b);
      // Odd rounds put operand and memory on opposite sides of zero
      if (i % 2 == 1) begin
        if (sz == SIZE_D) begin
          b[63] = ~seed[63];
        end else begin
          b[31] = a[2] ? ~seed[63] : ~seed[31];
        end
      end
      run_op(AMO_SWAP, SIZE_D, {a[7:3], 3'b000}, seed);
      draw_bits(8, r);
      run_op(op_from(8, 4, r), sz, a, b);
      run_op(AMO_LR, SIZE_D, {a[7:3], 3'b000}, '0);
    end
    end_test("min_max");

    begin_test("word_iso");
    for (int i = 0; i < 12; i++) begin
      draw_addr(SIZE_W, a);
      draw_bits(64, seed);
      draw_bits(64, b);
      draw_bits(8, r);
      run_op(AMO_SWAP, SIZE_D, {a[7:3], 3'b000}, seed);
      run_op(op_from(3, 9, r), SIZE_W, a, b);
      run_op(AMO_LR, SIZE_D, {a[7:3], 3'b000}, '0);
    end
    end_test("word_iso");

    begin_test("lr_sc");
    for (int i = 0; i < 2; i++) begin
      sz = (i == 0) ? SIZE_D : SIZE_W;
      draw_addr(sz, a);
      // Next word for 64-bit, other half of the same word for 32-bit
      a2 = (sz == SIZE_D) ? (a ^ 8'h08) : (a ^ 8'h04);
      draw_bits(64, b);
      run_op(AMO_LR, sz, a, '0);
      run_op(AMO_SC, sz, a, b);
      run_op(AMO_SC, sz, a, ~b);
      run_op(AMO_SC, sz, a2, b);
      run_op(AMO_LR, sz, a, '0);
      run_op(AMO_SC, sz, a2, ~b);
      run_op(AMO_LR, sz, a, '0);
      run_op(AMO_SC, sz, a, ~b);
      run_op(AMO_LR, SIZE_D, {a[7:3], 3'b000}, '0);
    end
    end_test("lr_sc");

    begin_test("timing");
    for (int i = 0; i < 30; i++) begin
      draw_bits(9, r);
      sz = r[8] ? SIZE_W : SIZE_D;
      draw_addr(sz, a);
      draw_bits(64, b);
      run_op(op_from(1, 11, r), sz, a, b);
    end
    end_test("timing");

    $display("tests %0d, ops %0d, checks %0d, errors %0d", test_cnt, op_cnt, chk_cnt, err_cnt);
    if (chk_cnt != op_cnt) begin
      $display("checker saw %0d responses for %0d requests", chk_cnt, op_cnt);
    end
    if (err_cnt == 0 && chk_cnt == op_cnt) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
source/amo_mem_pkg.sv
source/amo_ops_pkg.sv
source/amo_decode.sv
source/amo_execute.sv
source/amo_result.sv
source/amo_top.sv
test/amo_checker.sv
test/amo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the atomic memory unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module amo_tb \
  -Mdir obj_dir -o amo_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/amo_sim)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
